/* Uart.f */
+incdir+hdl
hdl/UartTypes.sv
hdl/UartFifoIf.sv
hdl/UartFifo.sv
hdl/UartTx.sv
hdl/UartRx.sv
hdl/UartRegs.sv
hdl/Uart.sv
bench/UartChecker.sv
bench/UartBench.sv

/* run.sh */
#!/bin/sh
# Build the UART testbench with Verilator, run it and look for the pass message
rm -rf obj_dir build.log sim.log
verilator --binary --timing -Wno-fatal --top-module UartBench -f Uart.f -o UartSim \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/UartSim > sim.log 2>&1 || true
cat sim.log
grep -q "All checks passed" sim.log && exit 0 || exit 1

/* bench/UartBench.sv */
// UART testbench top with clock, reset, stimulus table, bus driver and serial driver
`include "uart_macros.svh"

module UartBench;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int BitCycles = 9;
    localparam int StopCycles = 17;
    localparam int FrameCycles = 99;
    localparam int TableLength = 23;
    localparam int CycleLimit = TableLength * 2 * FrameCycles + 500;

    typedef enum {OpStatus, OpTxWrite, OpTxBurst, OpWaitTxIdle, OpRxSend, OpRxDrain} OpKind;

    typedef struct {
        OpKind kind;
        logic [7:0] data;
        logic badStop;
        logic [4:0] expStatus;
        logic [4:0] statusMask;
    } Step;

    Step steps [TableLength];
    logic [8:0] rxExpected [$];
    logic clk = 1'b0;
    logic rst = 1'b1;
    logic busWrite, busRead, uartRx, uartTx;
    logic [1:0] busAddr;
    logic [7:0] busWriteData;
    logic [31:0] busReadData;
    logic expTxPush, expReadPush;
    logic [31:0] expValue, expMask;
    int errorCount, checkCount, txPending;
    int seed = 30218;
    int cycles = 0;
    int benchErrors = 0;

    Uart u_Uart (
        .clk(clk), .rst(rst), .busWrite(busWrite), .busRead(busRead),
        .busAddr(busAddr), .busWriteData(busWriteData), .busReadData(busReadData),
        .uartTx(uartTx), .uartRx(uartRx)
    );

    UartChecker u_Checker (
        .clk(clk), .rst(rst), .uartTx(uartTx), .busRead(busRead),
        .busReadData(busReadData), .expTxPush(expTxPush), .expReadPush(expReadPush),
        .expValue(expValue), .expMask(expMask), .errorCount(errorCount),
        .checkCount(checkCount), .txPending(txPending)
    );

    initial begin
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CycleLimit) begin
            $display("Timeout: run did not finish within %0d cycles", CycleLimit);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic setStep(input int idx, input OpKind kind, input logic [7:0] data,
            input logic badStop, input logic [4:0] expStatus, input logic [4:0] mask);
        steps[idx] = '{kind, data, badStop, expStatus, mask};
    endtask

    // Registered result of a read strobe is back by the next falling edge
    task automatic readReg(input logic [1:0] addr, input logic [31:0] expected,
            input logic [31:0] mask, output logic [31:0] value);
        @(negedge clk);
        busRead = 1'b1;
        busAddr = addr;
        expReadPush = 1'b1;
        expValue = expected;
        expMask = mask;
        @(negedge clk);
        busRead = 1'b0;
        expReadPush = 1'b0;
        value = busReadData;
    endtask

    task automatic driveWrite(input logic [7:0] data, input logic accepted);
        @(negedge clk);
        busWrite = 1'b1;
        busAddr = `UartAddrData;
        busWriteData = data;
        expTxPush = accepted;
        expValue = {24'd0, data};
    endtask

    task automatic releaseBus();
        @(negedge clk);
        busWrite = 1'b0;
        expTxPush = 1'b0;
    endtask

    task automatic holdLine(input logic level, input int count);
        @(negedge clk);
        uartRx = level;
        repeat (count - 1) @(negedge clk);
    endtask

    task automatic sendFrame(input logic [7:0] data, input logic badStop);
        holdLine(1'b0, BitCycles);
        for (int i = 0; i < 8; i++) begin
            holdLine(data[i], BitCycles);
        end
        holdLine(!badStop, StopCycles);
        holdLine(1'b1, 4);
        // Receive FIFO keeps only the first Depth entries until read
        if (rxExpected.size() < `UartFifoDepth) begin
            rxExpected.push_back({badStop, data});
        end
    endtask

    task automatic runStep(input Step s);
        logic [31:0] value;
        logic [8:0] entry;
        case (s.kind)
            OpStatus: readReg(`UartAddrStatus, {27'd0, s.expStatus}, {27'd0, s.statusMask}, value);
            OpTxWrite: begin
                readReg(`UartAddrStatus, {27'd0, s.expStatus}, {27'd0, s.statusMask},
                    value);
                if (!value[0]) begin
                    driveWrite(s.data, 1'b1);
                    releaseBus();
                end
            end
            OpTxBurst: begin
                // Idle transmitter takes one byte and the FIFO the next Depth
                for (int i = 0; i < `UartFifoDepth + 2; i++) begin
                    driveWrite(s.data + 8'(i), i < `UartFifoDepth + 1);
                end
                releaseBus();
            end
            OpWaitTxIdle: begin
                do begin
                    readReg(`UartAddrStatus, 32'd0, 32'd0, value);
                end while (!value[1]);
            end
            OpRxSend: sendFrame(s.data, s.badStop);
            default: begin
                while (rxExpected.size() > 0) begin
                    entry = rxExpected.pop_front();
                    readReg(`UartAddrData, {23'd0, entry}, 32'hFFFFFFFF, value);
                end
                readReg(`UartAddrStatus, 32'd0, 32'h4, value);
            end
        endcase
    endtask

    initial begin
        busWrite = 1'b0;
        busRead = 1'b0;
        busAddr = 2'd0;
        busWriteData = 8'd0;
        uartRx = 1'b1;
        expTxPush = 1'b0;
        expReadPush = 1'b0;
        expValue = 32'd0;
        expMask = 32'd0;

        setStep(0, OpStatus, 8'h00, 1'b0, 5'b00010, 5'b10110);
        // First write finds the transmitter idle, later ones find it busy
        setStep(1, OpTxWrite, 8'hA5, 1'b0, 5'b00010, 5'b00011);
        setStep(2, OpTxWrite, 8'($random(seed)), 1'b0, 5'b00000, 5'b00011);
        setStep(3, OpTxWrite, 8'($random(seed)), 1'b0, 5'b00000, 5'b00011);
        setStep(4, OpWaitTxIdle, 8'h00, 1'b0, 5'd0, 5'd0);
        setStep(5, OpTxBurst, 8'($random(seed)), 1'b0, 5'd0, 5'd0);
        setStep(6, OpWaitTxIdle, 8'h00, 1'b0, 5'd0, 5'd0);
        setStep(7, OpRxSend, 8'h3C, 1'b0, 5'd0, 5'd0);
        setStep(8, OpRxSend, 8'($random(seed)), 1'b0, 5'd0, 5'd0);
        setStep(9, OpStatus, 8'h00, 1'b0, 5'b00100, 5'b01100);
        setStep(10, OpRxDrain, 8'h00, 1'b0, 5'd0, 5'd0);
        setStep(11, OpRxSend, 8'h81, 1'b1, 5'd0, 5'd0);
        setStep(12, OpStatus, 8'h00, 1'b0, 5'b01100, 5'b01100);
        setStep(13, OpRxDrain, 8'h00, 1'b0, 5'd0, 5'd0);
        // One frame more than the receive FIFO holds
        for (int i = 14; i < 19; i++) begin
            setStep(i, OpRxSend, 8'($random(seed)), 1'b0, 5'd0, 5'd0);
        end
        setStep(19, OpStatus, 8'h00, 1'b0, 5'b10100, 5'b10100);
        setStep(20, OpStatus, 8'h00, 1'b0, 5'b00000, 5'b10000);
        setStep(21, OpRxDrain, 8'h00, 1'b0, 5'd0, 5'd0);
        setStep(22, OpWaitTxIdle, 8'h00, 1'b0, 5'd0, 5'd0);

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < TableLength; i++) begin
            runStep(steps[i]);
        end
        repeat (10) @(negedge clk);

        if (txPending != 0) begin
            $display("%0d written bytes never appeared on uartTx", txPending);
            benchErrors++;
        end
        $display("Checks run: %0d, checker errors: %0d, bench errors: %0d",
            checkCount, errorCount, benchErrors);
        if (errorCount == 0 && benchErrors == 0) begin
            $display("All checks passed");
        end
        else begin
            $display("Checks failed");
        end
        $finish;
    end
endmodule

/* bench/UartChecker.sv */
// UART checker that decodes uartTx frames and bus reads and compares them with expectations
module UartChecker (
    input logic clk,
    input logic rst,
    input logic uartTx,
    input logic busRead,
    input logic [31:0] busReadData,
    input logic expTxPush,
    input logic expReadPush,
    input logic [31:0] expValue,
    input logic [31:0] expMask,
    output int errorCount,
    output int checkCount,
    output int txPending
);
    timeunit 1ns;
    timeprecision 1ps;

    // Frame sample points counted from the first low sample of the start bit
    localparam int StartSample = 5;
    localparam int FirstDataSample = 14;
    localparam int BitCycles = 9;
    localparam int StopSample = 86;

    logic [7:0] txQueue [$];
    logic [31:0] readValues [$];
    logic [31:0] readMasks [$];
    logic [7:0] txByte;
    logic [7:0] txExpected;
    logic [31:0] readValue;
    logic [31:0] readMask;
    logic readPending = 1'b0;
    logic started = 1'b0;
    logic lastTx = 1'b1;
    int txPos = 0;
    int errors = 0;
    int checks = 0;

    assign errorCount = errors;
    assign checkCount = checks;
    assign txPending = txQueue.size();

    always @(posedge clk) begin
        if (rst) begin
            started = 1'b0;
            readPending = 1'b0;
            txPos = 0;
            lastTx = 1'b1;
        end
        else begin
            // Right after reset and before any read
            if (!started) begin
                started = 1'b1;
                checks = checks + 2;
                if (uartTx !== 1'b1) begin
                    $display("FAIL %0t uartTx expected 1 got %b", $time, uartTx);
                    errors++;
                end
                if (busReadData !== 32'd0) begin
                    $display("FAIL %0t busReadData expected %h got %h", $time, 32'd0, busReadData);
                    errors++;
                end
            end

            // Registered read data belongs to the read one cycle back
            if (readPending) begin
                readValue = readValues.pop_front();
                readMask = readMasks.pop_front();
                // Polling reads carry an empty mask
                if (readMask != 32'd0) begin
                    checks++;
                    if (((busReadData ^ readValue) & readMask) !== 32'd0) begin
                        $display("FAIL %0t busReadData expected %h got %h (mask %h)",
                            $time, readValue, busReadData, readMask);
                        errors++;
                    end
                end
            end
            if (expReadPush) begin
                readValues.push_back(expValue);
                readMasks.push_back(expMask);
            end
            readPending = busRead;

            if (expTxPush) begin
                txQueue.push_back(expValue[7:0]);
            end

            // Serial frame decoder sampling mid-bit at 9-cycle spacing
            if (txPos == 0) begin
                if (lastTx && !uartTx) begin
                    txPos = 1;
                end
            end
            else begin
                txPos++;
                if (txPos == StartSample && uartTx !== 1'b0) begin
                    $display("FAIL %0t uartTx expected 0 got %b at start bit", $time, uartTx);
                    errors++;
                end
                if (txPos >= FirstDataSample && txPos < StopSample
                        && (txPos - FirstDataSample) % BitCycles == 0) begin
                    txByte = {uartTx, txByte[7:1]};
                end
                if (txPos == StopSample) begin
                    txPos = 0;
                    checks++;
                    if (uartTx !== 1'b1) begin
                        $display("FAIL %0t uartTx expected 1 got %b at stop bit", $time, uartTx);
                        errors++;
                    end
                    if (txQueue.size() == 0) begin
                        $display("Unexpected frame %h on uartTx at %0t", txByte, $time);
                        errors++;
                    end
                    else begin
                        txExpected = txQueue.pop_front();
                        if (txByte !== txExpected) begin
                            $display("FAIL %0t uartTx expected %h got %h",
                                $time, txExpected, txByte);
                            errors++;
                        end
                    end
                end
            end
            lastTx = uartTx;
        end
    end
endmodule

/* hdl/Uart.sv */
// UART top level joining the register block, both FIFOs, transmitter and receiver
`include "uart_macros.svh"

module Uart (
    input logic clk,
    input logic rst,
    input logic busWrite,
    input logic busRead,
    input logic [1:0] busAddr,
    input UartTypes::int8_t busWriteData,
    output logic [31:0] busReadData,
    output logic uartTx,
    input logic uartRx
);
    logic txIdle;
    logic rxOverrunPulse;

    UartFifoIf #(.T(UartTypes::int8_t)) txFifo ();
    UartFifoIf #(.T(UartTypes::RxEntry)) rxFifo ();

    UartRegs u_Regs (
        .clk(clk),
        .rst(rst),
        .busWrite(busWrite),
        .busRead(busRead),
        .busAddr(busAddr),
        .busWriteData(busWriteData),
        .busReadData(busReadData),
        .txIdle(txIdle),
        .rxOverrunPulse(rxOverrunPulse),
        .tx(txFifo.producer),
        .rx(rxFifo.consumer)
    );

    UartFifo #(.T(UartTypes::int8_t), .Depth(`UartFifoDepth)) u_TxFifo (
        .clk(clk),
        .rst(rst),
        .port(txFifo.fifo)
    );

    UartFifo #(.T(UartTypes::RxEntry), .Depth(`UartFifoDepth)) u_RxFifo (
        .clk(clk),
        .rst(rst),
        .port(rxFifo.fifo)
    );

    UartTx u_Tx (
        .clk(clk),
        .rst(rst),
        .src(txFifo.consumer),
        .idle(txIdle),
        .uartTx(uartTx)
    );

    UartRx u_Rx (
        .clk(clk),
        .rst(rst),
        .uartRx(uartRx),
        .dst(rxFifo.producer),
        .overrun(rxOverrunPulse)
    );
endmodule

/* hdl/UartRegs.sv */
// UART bus register block with data and status registers and sticky overrun flag
`include "uart_macros.svh"

module UartRegs (
    input logic clk,
    input logic rst,
    input logic busWrite,
    input logic busRead,
    input logic [1:0] busAddr,
    input UartTypes::int8_t busWriteData,
    output logic [31:0] busReadData,
    input logic txIdle,
    input logic rxOverrunPulse,
    UartFifoIf.producer tx,
    UartFifoIf.consumer rx
);
    UartTypes::StatusBits status;
    logic rxOverrun;
    logic writeData;
    logic readData;
    logic readStatus;

    assign writeData = busWrite && (busAddr == `UartAddrData);
    assign readData = busRead && (busAddr == `UartAddrData);
    assign readStatus = busRead && (busAddr == `UartAddrStatus);

    // Bytes written while full are dropped
    assign tx.push = writeData && !tx.full;
    assign tx.pushData = busWriteData;
    assign rx.pop = readData && !rx.empty;

    always_comb begin
        status.txFull = tx.full;
        status.txIdle = txIdle;
        status.rxValid = !rx.empty;
        // Only meaningful while an entry is at the head
        status.rxFramingError = !rx.empty && rx.popData.framingError;
        status.rxOverrun = rxOverrun;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busReadData <= '0;
            rxOverrun <= 1'b0;
        end
        else begin
            if (readData) begin
                busReadData <= rx.empty ? '0 : 32'(rx.popData);
            end
            else if (readStatus) begin
                busReadData <= 32'(status);
            end
            else if (busRead) begin
                busReadData <= '0;
            end

            // A new overrun wins over the clear from a status read
            if (rxOverrunPulse) begin
                rxOverrun <= 1'b1;
            end
            else if (readStatus) begin
                rxOverrun <= 1'b0;
            end
        end
    end
endmodule

/* hdl/UartRx.sv */
// UART receiver with input synchronizer, mid-bit sampling FSM and framing check
`include "uart_macros.svh"

module UartRx (
    input logic clk,
    input logic rst,
    input logic uartRx,
    UartFifoIf.producer dst,
    output logic overrun
);
    localparam int CycleLength = `UartClockFrequency / `UartBaudRate;
    localparam int HalfLength = CycleLength / 2;
    localparam int CountWidth = $clog2(CycleLength + 1);

    typedef enum logic [1:0] {
        StateIdle,
        StateStartBit,
        StateData,
        StateStopBit
    } State;

    State state;
    logic [1:0] sync;
    logic line;
    logic lineLast;
    logic [CountWidth-1:0] cycleCount;
    logic [2:0] bitCount;
    UartTypes::int8_t shiftReg;
    logic sampleNow;
    logic stopSample;

    assign line = sync[1];

    // Start bit is checked half a bit after the edge, then one sample per bit
    always_comb begin
        case (state)
            StateStartBit: sampleNow = (cycleCount == CountWidth'(HalfLength - 1));
            StateData, StateStopBit: sampleNow = (cycleCount == CountWidth'(CycleLength));
            default: sampleNow = 1'b0;
        endcase
    end

    assign stopSample = (state == StateStopBit) && sampleNow;

    // A low stop bit marks the entry, a full FIFO drops it
    assign dst.push = stopSample && !dst.full;
    assign dst.pushData = '{framingError: !line, data: shiftReg};
    assign overrun = stopSample && dst.full;

    always_ff @(posedge clk) begin
        if (rst) begin
            sync <= 2'b11;
            lineLast <= 1'b1;
            state <= StateIdle;
            cycleCount <= '0;
            bitCount <= '0;
        end
        else begin
            sync <= {sync[0], uartRx};
            lineLast <= line;

            if (state == StateIdle || sampleNow) begin
                cycleCount <= '0;
            end
            else begin
                cycleCount <= cycleCount + 1'b1;
            end

            case (state)
                StateIdle: begin
                    // Falling edge after the synchronizer
                    if (lineLast && !line) begin
                        state <= StateStartBit;
                    end
                end
                StateStartBit: begin
                    // Line back high means a glitch, not a start bit
                    if (sampleNow) begin
                        state <= line ? StateIdle : StateData;
                    end
                end
                StateData: begin
                    if (sampleNow) begin
                        bitCount <= bitCount + 1'b1;
                        if (bitCount == 3'd7) begin
                            state <= StateStopBit;
                        end
                    end
                end
                default: begin
                    if (sampleNow) begin
                        state <= StateIdle;
                    end
                end
            endcase
        end
    end

    // Bits arrive LSB first
    always_ff @(posedge clk) begin
        if (state == StateData && sampleNow) begin
            shiftReg <= {line, shiftReg[7:1]};
        end
    end
endmodule

/* hdl/UartTx.sv */
// UART transmitter FSM that pops bytes from its FIFO and drives the serial line
`include "uart_macros.svh"

module UartTx (
    input logic clk,
    input logic rst,
    UartFifoIf.consumer src,
    output logic idle,
    output logic uartTx
);
    localparam int CycleLength = `UartClockFrequency / `UartBaudRate;
    localparam int StopLength = 2 * CycleLength;
    localparam int CountWidth = $clog2(StopLength + 1);

    typedef enum logic [2:0] {
        StateNone,
        StateStartBit,
        StateData,
        StateStopBit,
        StateClearBuffer
    } State;

    State state;
    logic [CountWidth-1:0] cycleCount;
    logic [3:0] bitCount;
    UartTypes::int8_t buffer;
    logic bitEnd;

    // Start and data bits last CycleLength+1 cycles
    assign bitEnd = (cycleCount == CountWidth'(CycleLength));

    // Take the next byte as soon as the line is free
    assign src.pop = (state == StateNone) && !src.empty;

    // Idle only when nothing is queued either
    assign idle = (state == StateNone) && src.empty;

    always_comb begin
        case (state)
            StateStartBit: uartTx = 1'b0;
            StateData: uartTx = buffer[0];
            default: uartTx = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= StateNone;
            cycleCount <= '0;
            bitCount <= '0;
        end
        else begin
            case (state)
                StateNone: begin
                    cycleCount <= '0;
                    bitCount <= '0;
                    if (src.pop) begin
                        state <= StateStartBit;
                    end
                end
                StateStartBit: begin
                    if (bitEnd) begin
                        cycleCount <= '0;
                        state <= StateData;
                    end
                    else begin
                        cycleCount <= cycleCount + 1'b1;
                    end
                end
                StateData: begin
                    if (bitEnd) begin
                        cycleCount <= '0;
                        if (bitCount == 4'd7) begin
                            bitCount <= '0;
                            state <= StateStopBit;
                        end
                        else begin
                            bitCount <= bitCount + 1'b1;
                        end
                    end
                    else begin
                        cycleCount <= cycleCount + 1'b1;
                    end
                end
                StateStopBit: begin
                    // Stop bit is twice as long as a data bit
                    if (cycleCount == CountWidth'(StopLength)) begin
                        cycleCount <= '0;
                        state <= StateClearBuffer;
                    end
                    else begin
                        cycleCount <= cycleCount + 1'b1;
                    end
                end
                default: begin
                    state <= StateNone;
                end
            endcase
        end
    end

    // LSB goes out first, so shift right after each data bit
    always_ff @(posedge clk) begin
        if (src.pop) begin
            buffer <= src.popData;
        end
        else if (state == StateData && bitEnd) begin
            buffer <= buffer >> 1;
        end
    end

    assert property (@(posedge clk) disable iff (rst) bitCount <= 4'd7)
        else $error("UartTx: bit count beyond the last data bit");
endmodule

/* hdl/UartFifo.sv */
// Circular FIFO for any payload type, with occupancy count and protocol assertions
`include "uart_macros.svh"

module UartFifo #(
    parameter type T = UartTypes::int8_t,
    parameter int Depth = `UartFifoDepth
)(
    input logic clk,
    input logic rst,
    UartFifoIf.fifo port
);
    localparam int PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int CountWidth = $clog2(Depth + 1);

    T mem [Depth];
    logic [PtrWidth-1:0] readPtr;
    logic [PtrWidth-1:0] writePtr;
    logic [CountWidth-1:0] count;
    logic doPush;
    logic doPop;

    assign port.full = (count == CountWidth'(Depth));
    assign port.empty = (count == '0);
    assign port.popData = mem[readPtr];

    // Only legal requests take effect
    assign doPush = port.push && !port.full;
    assign doPop = port.pop && !port.empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            readPtr <= '0;
            writePtr <= '0;
            count <= '0;
        end
        else begin
            if (doPush) begin
                writePtr <= (writePtr == PtrWidth'(Depth - 1)) ? '0 : writePtr + 1'b1;
            end
            if (doPop) begin
                readPtr <= (readPtr == PtrWidth'(Depth - 1)) ? '0 : readPtr + 1'b1;
            end
            count <= count + CountWidth'(doPush) - CountWidth'(doPop);
        end
    end

    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[writePtr] <= port.pushData;
        end
    end

    // Producers and consumers are expected to check the levels themselves
    assert property (@(posedge clk) disable iff (rst) !(port.push && port.full))
        else $error("UartFifo: push while full");
    assert property (@(posedge clk) disable iff (rst) !(port.pop && port.empty))
        else $error("UartFifo: pop while empty");
endmodule

/* hdl/UartFifoIf.sv */
// Push and pop interface between a UART FIFO and its producer and consumer
interface UartFifoIf #(
    parameter type T = UartTypes::int8_t
);
    // Write side
    logic push;
    T pushData;
    logic full;

    // Read side, popData shows the head entry while not empty
    logic pop;
    T popData;
    logic empty;

    modport producer (
        output push,
        output pushData,
        input full
    );

    modport consumer (
        output pop,
        input popData,
        input empty
    );

    modport fifo (
        input push,
        input pushData,
        output full,
        input pop,
        output popData,
        output empty
    );
endinterface

/* hdl/UartTypes.sv */
// Package with the UART byte type, receive entry and status register layout
package UartTypes;

    // One data byte on the serial line
    typedef logic [7:0] int8_t;

    // Receive FIFO entry
    // Framing flag sits above the byte, so it lands in bit 8 of a data read
    typedef struct packed {
        logic framingError;
        int8_t data;
    } RxEntry;

    // Status register, txFull in bit 0 up to rxOverrun in bit 4
    typedef struct packed {
        logic rxOverrun;
        logic rxFramingError;
        logic rxValid;
        logic txIdle;
        logic txFull;
    } StatusBits;

endpackage

/* hdl/uart_macros.svh */
// Build-time UART clocking, FIFO depth and register address macros
`ifndef UartMacrosSvh
`define UartMacrosSvh

// System clock and serial line rate
`define UartClockFrequency 80
`define UartBaudRate 10

// Entries per FIFO
`define UartFifoDepth 4

// Register map on the 2-bit bus address
`define UartAddrData 2'd0
`define UartAddrStatus 2'd1

`endif
